//--- filelist.f
source/exePkg.sv
source/aluUnit.sv
source/branchUnit.sv
source/mulUnit.sv
source/trapUnit.sv
source/exeStage.sv
dv/exeStage_chk.sv
dv/exeStageTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the exeStage testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --timescale 1ns/1ps \
	-f filelist.f --top-module exeStageTb -Mdir obj_dir -o simExe
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

# keep running past checker errors so the testbench prints its own verdict
./obj_dir/simExe +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Test OK" sim.log; then
	exit 0
else
	echo "pass message not found in sim.log"
	exit 1
fi

//--- dv/exeStageTb.sv
`default_nettype none

module exeStageTb import exePkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int stimCycles = 240;
	localparam int timeoutCycles = 3 * stimCycles;
	localparam logic [31:0] edgeVals [4] = '{32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff, 32'h1};

	typedef struct packed
	{
		logic we;
		logic [4:0] rd;
		logic [31:0] data;
		logic [31:0] pc;
		logic bj; // branch or jump, target is checked
		logic taken;
		logic [31:0] target;
		logic [3:0] flt; // misaligned, ecall, illegal, mret
	} expEntry_t;

	logic clk, nrst;
	logic [xlen-1:0] opA, opB, bImm, jImm, uImm, pc;
	logic [regAddrW-1:0] rd;
	logic we, branch, branchNe, jal, jalr;
	logic fetchMisaligned, ecall, illegal, mret;
	aluOp_t aluOp;
	wbSel_t wbSel;
	mulOp_t mulOp;
	privMode_t mode;
	logic mTimer, sTimer, extIrq, mTie, sTie, mEie, sEie;
	logic [xlen-1:0] wbData, target, cause, trapPc;
	logic [regAddrW-1:0] wbRd;
	logic wbWe, bjTaken, trap, mretOut;

	expEntry_t curExp, e1, e2; // issue, pipe 5 and pipe 6 of the model
	logic [32:0] expTc; // {trap, cause}
	logic [31:0] curPc = 32'h0000_1000;
	logic checkOn = 1'b0;
	int errors = 0;
	int cycles = 0;

	exeStage DUT (.*);

	bind exeStage exeStage_chk chk (.clk(clk), .nrst(nrst), .trap(trap), .wbWe(wbWe),
		.bjTaken(bjTaken), .mretOut(mretOut), .trapPc(trapPc), .pc5(pc5));

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] aluModel(aluOp_t op, logic [31:0] a, logic [31:0] b);
		case (op)
			aluAdd: return a + b;
			aluSub: return a - b;
			aluSll: return a << b[4:0];
			aluSlt: return {31'd0, (a[31] != b[31]) ? a[31] : (a < b)};
			aluSltu: return {31'd0, a < b};
			aluXor: return a ^ b;
			aluSrl: return a >> b[4:0];
			aluSra: return 32'({{32{a[31]}}, a} >> b[4:0]);
			aluOr: return a | b;
			aluAnd: return a & b;
			default: return '0;
		endcase
	endfunction

	function automatic logic [31:0] mulModel(mulOp_t op, logic [31:0] a, logic [31:0] b);
		logic [63:0] sa;
		logic [63:0] p;
		sa = {{32{a[31]}}, a};
		case (op)
			mulHigh: p = sa * {{32{b[31]}}, b};
			mulHighSu: p = sa * {32'd0, b}; // mod 2^64 is enough for the top half
			default: p = {32'd0, a} * {32'd0, b};
		endcase
		return (op == mulLo) ? p[31:0] : p[63:32];
	endfunction

	// irq = {mTimer, sTimer, extIrq, mTie, sTie, mEie, sEie}
	function automatic logic [32:0] expectCause(logic [3:0] flt, privMode_t m, logic [6:0] irq);
		logic sOk;
		sOk = (m != modeMachine);
		if (irq[4] && irq[1])
			return {2'b11, mExtInt};
		if (irq[4] && irq[0] && sOk)
			return {2'b11, sExtInt};
		if (irq[6] && irq[3])
			return {2'b11, mTimerInt};
		if (irq[5] && irq[2] && sOk)
			return {2'b11, sTimerInt};
		if (flt[3])
			return {2'b10, instrMisaligned};
		if (flt[2])
			return {2'b10, userEcall + 31'(m)};
		if (flt[1])
			return {2'b10, illegalInstr};
		return {flt[0], 32'd0}; // mret, cause 0
	endfunction

	assign expTc = expectCause(e2.flt, mode, {mTimer, sTimer, extIrq, mTie, sTie, mEie, sEie});

	// model pipe, a trap empties both stages but pipe 6 keeps the pc
	always @(posedge clk)
	begin
		if (expTc[32])
		begin
			e1 <= '0;
			e2 <= '0;
			e2.pc <= e1.pc;
		end
		else
		begin
			e1 <= curExp;
			e2 <= e1;
		end
	end

	task automatic reportMismatch(string what, logic [31:0] got, logic [31:0] want);
		errors++;
		$display("mismatch at %0t: %s is %h, expected %h", $time, what, got, want);
	endtask

	always @(negedge clk)
	begin
		if (checkOn)
		begin
			assert (trap == expTc[32]) else reportMismatch("trap", 32'(trap), 32'(expTc[32]));
			if (expTc[32])
				assert (cause == expTc[31:0]) else reportMismatch("cause", cause, expTc[31:0]);
			assert (wbWe == e2.we) else reportMismatch("wbWe", 32'(wbWe), 32'(e2.we));
			if (e2.we)
			begin
				assert (wbRd == e2.rd) else reportMismatch("wbRd", 32'(wbRd), 32'(e2.rd));
				assert (wbData == e2.data) else reportMismatch("wbData", wbData, e2.data);
			end
			assert (trapPc == e2.pc) else reportMismatch("trapPc", trapPc, e2.pc);
			assert (mretOut == e2.flt[0])
				else reportMismatch("mretOut", 32'(mretOut), 32'(e2.flt[0]));
			assert (bjTaken == e1.taken) else reportMismatch("bjTaken", 32'(bjTaken), 32'(e1.taken));
			if (e1.bj)
				assert (target == e1.target) else reportMismatch("target", target, e1.target);
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= timeoutCycles)
		begin
			$display("timeout: run did not finish within %0d cycles", timeoutCycles);
			$display("Test FAILED");
			$finish;
		end
	end

	// next edge, every issue input back to a bubble
	task automatic beginCycle(output expEntry_t e);
		@(posedge clk);
		{we, branch, branchNe, jal, jalr} <= '0;
		{fetchMisaligned, ecall, illegal, mret} <= '0;
		{opA, opB, bImm, jImm, uImm} <= '0;
		rd <= '0;
		aluOp <= aluAdd;
		wbSel <= wbAlu;
		mulOp <= mulLo;
		pc <= curPc;
		e = '0;
		e.pc = curPc;
		curPc = curPc + 32'd4;
	endtask

	task automatic bubble();
		expEntry_t e;
		beginCycle(e);
		curExp <= e;
	endtask

	task automatic issueAlu(aluOp_t op, logic [31:0] a, logic [31:0] b);
		expEntry_t e;
		beginCycle(e);
		e.we = 1'b1;
		e.rd = 5'($urandom_range(31, 1));
		e.data = aluModel(op, a, b);
		{opA, opB, aluOp, we, rd} <= {a, b, op, 1'b1, e.rd};
		curExp <= e;
	endtask

	task automatic issueMul(mulOp_t op, logic [31:0] a, logic [31:0] b);
		expEntry_t e;
		beginCycle(e);
		e.we = 1'b1;
		e.rd = 5'($urandom_range(31, 1));
		e.data = mulModel(op, a, b);
		{opA, opB, mulOp, wbSel, we, rd} <= {a, b, op, wbMul, 1'b1, e.rd};
		curExp <= e;
	endtask

	task automatic issueUpper(wbSel_t sel, logic [31:0] imm);
		expEntry_t e;
		beginCycle(e);
		e.we = 1'b1;
		e.rd = 5'($urandom_range(31, 1));
		e.data = (sel == wbLui) ? imm : imm + e.pc;
		{uImm, wbSel, we, rd} <= {imm, sel, 1'b1, e.rd};
		curExp <= e;
	endtask

	task automatic issueBranch(logic ne, logic [31:0] a, logic [31:0] b, logic [31:0] imm);
		expEntry_t e;
		beginCycle(e);
		e.bj = 1'b1;
		e.taken = (a == b) ^ ne;
		e.target = e.pc + imm;
		{opA, opB, bImm, branch, branchNe} <= {a, b, imm, 1'b1, ne};
		curExp <= e;
	endtask

	task automatic issueJump(logic isJalr, logic [31:0] a, logic [31:0] imm);
		expEntry_t e;
		beginCycle(e);
		e.we = 1'b1;
		e.rd = 5'($urandom_range(31, 1));
		e.data = e.pc + 32'd4; // link
		e.bj = 1'b1;
		e.taken = 1'b1;
		e.target = isJalr ? ((a + imm) & ~32'h1) : e.pc + imm;
		{opA, opB, jImm, jal, jalr} <= {a, imm, imm, ~isJalr, isJalr};
		{wbSel, we, rd} <= {wbLink, 1'b1, e.rd};
		curExp <= e;
	endtask

	// fault then two bubbles, so the next case is not lost to the flush
	task automatic trapCase(logic [3:0] f);
		expEntry_t e;
		beginCycle(e);
		e.flt = f;
		{fetchMisaligned, ecall, illegal, mret} <= f;
		curExp <= e;
		bubble();
		bubble();
	endtask

	task automatic irqCase(privMode_t m, logic [6:0] v);
		issueAlu(aluAdd, $urandom, $urandom);
		mode <= m;
		{mTimer, sTimer, extIrq, mTie, sTie, mEie, sEie} <= v; // held for one cycle
		bubble();
		{mTimer, sTimer, extIrq, mTie, sTie, mEie, sEie} <= '0;
		bubble();
		bubble();
	endtask

	initial
	begin
		void'($urandom(85349));
		nrst = 1'b0;
		{opA, opB, bImm, jImm, uImm, pc, rd} = '0;
		{we, branch, branchNe, jal, jalr} = '0;
		{fetchMisaligned, ecall, illegal, mret} = '0;
		aluOp = aluAdd;
		wbSel = wbAlu;
		mulOp = mulLo;
		mode = modeMachine;
		{mTimer, sTimer, extIrq, mTie, sTie, mEie, sEie} = '0;
		curExp = '0;
		e1 = '0;
		e2 = '0;
		repeat (5) @(posedge clk);
		nrst <= 1'b1;
		checkOn <= 1'b1;

		for (int i = 0; i < 60; i++)
			issueAlu(aluOp_t'($urandom_range(9, 0)), $urandom, $urandom);

		issueBranch(1'b0, 32'd7, 32'd7, 32'h40); // beq taken
		issueBranch(1'b0, 32'd7, 32'd8, 32'h40);
		issueBranch(1'b1, 32'hffff_fff0, 32'd3, 32'hffff_fff0); // bne back
		issueBranch(1'b1, 32'd5, 32'd5, 32'h80);
		issueJump(1'b0, 32'd0, 32'h100);
		issueJump(1'b1, 32'h2001, 32'h10); // odd sum, bit 0 dropped

		for (int m = 0; m < 4; m++)
		begin
			for (int i = 0; i < 4; i++)
				for (int j = 0; j < 4; j++)
					issueMul(mulOp_t'(m), edgeVals[i], edgeVals[j]);
			issueMul(mulOp_t'(m), $urandom, $urandom);
			issueMul(mulOp_t'(m), $urandom, $urandom);
		end

		issueUpper(wbLui, 32'hdead_b000);
		issueUpper(wbAuipc, 32'h0001_2000);
		issueUpper(wbLui, $urandom);
		issueUpper(wbAuipc, $urandom);

		for (int m = 0; m < 4; m++)
		begin
			if (m != 2)
			begin
				mode <= privMode_t'(m);
				trapCase(4'b0100); // ecall, cause follows mode
				trapCase(4'b1110); // misaligned wins
				trapCase(4'b0110);
				trapCase(4'b0010);
				trapCase(4'b0001); // mret
			end
		end

		irqCase(modeUser, 7'b111_1111); // everything pending, mExt first
		irqCase(modeSupervisor, 7'b001_0001);
		irqCase(modeMachine, 7'b001_0001); // s-level masked in machine mode
		irqCase(modeUser, 7'b110_1100);
		irqCase(modeSupervisor, 7'b010_0100);
		irqCase(modeMachine, 7'b100_0000); // pending but disabled
		irqCase(modeUser, 7'b001_0000);

		repeat (4) bubble();
		$display("errors: %0d scoreboard, %0d checker", errors, DUT.chk.failCount);
		if (errors == 0 && DUT.chk.failCount == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/exeStage_chk.sv
`default_nettype none

module exeStage_chk import exePkg::*;
(
	input logic clk,
	input logic nrst,
	input logic trap,
	input logic wbWe,
	input logic bjTaken,
	input logic mretOut,
	input logic [xlen-1:0] trapPc,
	input logic [xlen-1:0] pc5
);
	timeunit 1ns;
	timeprecision 1ps;

	int failCount = 0;

	// outputs stay quiet while in reset
	resetQuiet: assert property (@(posedge clk) !nrst |-> !wbWe && !bjTaken && !trap)
		else
		begin
			failCount++;
			$error("outputs active during reset");
		end

	flushClears: assert property (@(posedge clk) disable iff (!nrst)
		trap |=> !wbWe && !mretOut && !bjTaken)
		else
		begin
			failCount++;
			$error("pipe not flushed after trap");
		end

	// pipe 6 keeps the pc that sat in pipe 5 at the trap edge
	trapPcHeld: assert property (@(posedge clk) disable iff (!nrst)
		trap |=> trapPc == $past(pc5))
		else
		begin
			failCount++;
			$error("trapPc lost across flush");
		end

endmodule

`default_nettype wire

//--- source/exeStage.sv
`default_nettype none

module exeStage import exePkg::*;
(
	input logic clk,
	input logic nrst,
	input logic [xlen-1:0] opA,
	input logic [xlen-1:0] opB,
	input logic [regAddrW-1:0] rd,
	input logic we,
	input aluOp_t aluOp,
	input wbSel_t wbSel,
	input mulOp_t mulOp,
	input logic [xlen-1:0] bImm,
	input logic [xlen-1:0] jImm,
	input logic [xlen-1:0] uImm,
	input logic [xlen-1:0] pc,
	input logic branch,
	input logic branchNe,
	input logic jal,
	input logic jalr,
	input logic fetchMisaligned,
	input logic ecall,
	input logic illegal,
	input logic mret,
	input privMode_t mode,
	input logic mTimer,
	input logic sTimer,
	input logic extIrq,
	input logic mTie,
	input logic sTie,
	input logic mEie,
	input logic sEie,
	output logic [xlen-1:0] wbData,
	output logic wbWe,
	output logic [regAddrW-1:0] wbRd,
	output logic [xlen-1:0] target,
	output logic bjTaken,
	output logic trap,
	output logic [xlen-1:0] cause,
	output logic [xlen-1:0] trapPc,
	output logic mretOut
);

	// pipe 5
	logic [xlen-1:0] opA5, opB5, bImm5, jImm5, uImm5, pc5;
	logic [regAddrW-1:0] rd5;
	aluOp_t aluOp5;
	wbSel_t wbSel5;
	mulOp_t mulOp5;
	logic we5, branch5, branchNe5, jal5, jalr5;
	logic fetchMis5, ecall5, illegal5, mret5;

	// pipe 6
	logic [xlen-1:0] alu6, link6, mul6, lui6, auipc6, pc6;
	logic [regAddrW-1:0] rd6;
	wbSel_t wbSel6;
	logic we6, fetchMis6, ecall6, illegal6, mret6;

	logic [xlen-1:0] aluRes5, mulRes5;
	logic cond5;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			{we5, branch5, branchNe5, jal5, jalr5} <= '0;
			{fetchMis5, ecall5, illegal5, mret5} <= '0;
			aluOp5 <= aluAdd;
			wbSel5 <= wbAlu;
			mulOp5 <= mulLo;
		end
		else if (trap)
		begin
			{we5, branch5, branchNe5, jal5, jalr5} <= '0; // squash
			{fetchMis5, ecall5, illegal5, mret5} <= '0;
			aluOp5 <= aluAdd;
			wbSel5 <= wbAlu;
			mulOp5 <= mulLo;
		end
		else
		begin
			{we5, branch5, branchNe5, jal5, jalr5} <= {we, branch, branchNe, jal, jalr};
			{fetchMis5, ecall5, illegal5, mret5} <= {fetchMisaligned, ecall, illegal, mret};
			aluOp5 <= aluOp;
			wbSel5 <= wbSel;
			mulOp5 <= mulOp;
		end
	end

	always_ff @(posedge clk)
	begin
		if (trap)
			{opA5, opB5, bImm5, jImm5, uImm5, pc5, rd5} <= '0;
		else
			{opA5, opB5, bImm5, jImm5, uImm5, pc5, rd5} <= {opA, opB, bImm, jImm, uImm, pc, rd};
	end

	aluUnit alu (.aluOp(aluOp5), .a(opA5), .b(opB5), .branchNe(branchNe5),
		.result(aluRes5), .cond(cond5));

	// opB carries the I immediate for jalr
	branchUnit bu (.pc(pc5), .a(opA5), .bImm(bImm5), .jImm(jImm5), .iImm(opB5),
		.cond(cond5), .branch(branch5), .jal(jal5), .jalr(jalr5),
		.target(target), .taken(bjTaken));

	mulUnit mul (.mulOp(mulOp5), .a(opA5), .b(opB5), .result(mulRes5));

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			{we6, fetchMis6, ecall6, illegal6, mret6} <= '0;
			wbSel6 <= wbAlu;
		end
		else if (trap)
		begin
			{we6, fetchMis6, ecall6, illegal6, mret6} <= '0;
			wbSel6 <= wbAlu;
		end
		else
		begin
			{we6, fetchMis6, ecall6, illegal6, mret6} <= {we5, fetchMis5, ecall5, illegal5, mret5};
			wbSel6 <= wbSel5;
		end
	end

	always_ff @(posedge clk)
	begin
		pc6 <= pc5; // survives the flush as trapPc
		if (trap)
			{alu6, link6, mul6, lui6, auipc6, rd6} <= '0;
		else
		begin
			alu6 <= aluRes5;
			link6 <= pc5 + 32'd4;
			mul6 <= mulRes5;
			lui6 <= uImm5;
			auipc6 <= uImm5 + pc5;
			rd6 <= rd5;
		end
	end

	trapUnit tu (.mode(mode), .mTimer(mTimer), .sTimer(sTimer), .extIrq(extIrq),
		.mTie(mTie), .sTie(sTie), .mEie(mEie), .sEie(sEie),
		.fetchMisaligned(fetchMis6), .ecall(ecall6), .illegal(illegal6), .mret(mret6),
		.trap(trap), .cause(cause));

	always_comb
	begin
		case (wbSel6)
			wbLink: wbData = link6;
			wbMul: wbData = mul6;
			wbLui: wbData = lui6;
			wbAuipc: wbData = auipc6;
			default: wbData = alu6;
		endcase
	end

	assign wbWe = we6;
	assign wbRd = rd6;
	assign trapPc = pc6;
	assign mretOut = mret6;

endmodule

`default_nettype wire

//--- source/trapUnit.sv
`default_nettype none

module trapUnit import exePkg::*;
(
	input privMode_t mode,
	input logic mTimer,
	input logic sTimer,
	input logic extIrq,
	input logic mTie,
	input logic sTie,
	input logic mEie,
	input logic sEie,
	input logic fetchMisaligned,
	input logic ecall,
	input logic illegal,
	input logic mret,
	output logic trap,
	output logic [xlen-1:0] cause
);

	logic sAllowed;
	logic mExtPend;
	logic sExtPend;
	logic mTimerPend;
	logic sTimerPend;
	logic anyInt;

	// supervisor interrupts are masked while in machine mode
	assign sAllowed = (mode != modeMachine);

	assign mExtPend = mEie & extIrq;
	assign sExtPend = sAllowed & sEie & extIrq;
	assign mTimerPend = mTie & mTimer;
	assign sTimerPend = sAllowed & sTie & sTimer;

	assign anyInt = mExtPend | sExtPend | mTimerPend | sTimerPend;
	assign trap = anyInt | fetchMisaligned | ecall | illegal | mret;

	always_comb
	begin
		cause = '0; // mret also lands here
		cause[xlen-1] = anyInt;
		if (mExtPend)
			cause[xlen-2:0] = mExtInt;
		else if (sExtPend)
			cause[xlen-2:0] = sExtInt;
		else if (mTimerPend)
			cause[xlen-2:0] = mTimerInt;
		else if (sTimerPend)
			cause[xlen-2:0] = sTimerInt;
		else if (fetchMisaligned)
			cause[xlen-2:0] = instrMisaligned;
		else if (ecall)
			cause[xlen-2:0] = userEcall + 31'(mode); // 8, 9 or 11
		else if (illegal)
			cause[xlen-2:0] = illegalInstr;
	end

endmodule

`default_nettype wire

//--- source/mulUnit.sv
`default_nettype none

module mulUnit import exePkg::*;
(
	input mulOp_t mulOp,
	input logic [xlen-1:0] a,
	input logic [xlen-1:0] b,
	output logic [xlen-1:0] result
);

	logic aSigned;
	logic bSigned;
	logic signed [xlen:0] aExt; // one extra bit carries the sign choice
	logic signed [xlen:0] bExt;
	logic signed [2*xlen+1:0] prodFull;
	logic [2*xlen-1:0] prod;

	always_comb
	begin
		case (mulOp)
			mulHigh:
			begin
				aSigned = 1'b1;
				bSigned = 1'b1;
			end
			mulHighSu:
			begin
				aSigned = 1'b1;
				bSigned = 1'b0;
			end
			default:
			begin
				aSigned = 1'b0; // low half is the same either way
				bSigned = 1'b0;
			end
		endcase
	end

	assign aExt = {aSigned & a[xlen-1], a};
	assign bExt = {bSigned & b[xlen-1], b};
	assign prodFull = aExt * bExt;
	assign prod = prodFull[2*xlen-1:0];

	assign result = (mulOp == mulLo) ? prod[xlen-1:0] : prod[2*xlen-1:xlen];

endmodule

`default_nettype wire

//--- source/branchUnit.sv
`default_nettype none

module branchUnit import exePkg::*;
(
	input logic [xlen-1:0] pc,
	input logic [xlen-1:0] a,
	input logic [xlen-1:0] bImm,
	input logic [xlen-1:0] jImm,
	input logic [xlen-1:0] iImm,
	input logic cond,
	input logic branch,
	input logic jal,
	input logic jalr,
	output logic [xlen-1:0] target,
	output logic taken
);

	logic [xlen-1:0] regTarget;

	assign regTarget = a + iImm;

	always_comb
	begin
		if (jal)
			target = pc + jImm;
		else if (jalr)
			target = {regTarget[xlen-1:1], 1'b0}; // lsb cleared per spec
		else
			target = pc + bImm;
	end

	assign taken = jal | jalr | (branch & cond);

endmodule

`default_nettype wire

//--- source/aluUnit.sv
`default_nettype none

module aluUnit import exePkg::*;
(
	input aluOp_t aluOp,
	input logic [xlen-1:0] a,
	input logic [xlen-1:0] b,
	input logic branchNe,
	output logic [xlen-1:0] result,
	output logic cond
);

	logic [xlen-1:0] diff;
	logic [4:0] shamt;

	assign diff = a - b;
	assign shamt = b[4:0]; // only low five bits shift

	always_comb
	begin
		case (aluOp)
			aluAdd: result = a + b;
			aluSub: result = diff;
			aluSll: result = a << shamt;
			aluSlt: result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
			aluSltu: result = {{(xlen-1){1'b0}}, a < b};
			aluXor: result = a ^ b;
			aluSrl: result = a >> shamt;
			aluSra: result = $unsigned($signed(a) >>> shamt);
			aluOr: result = a | b;
			aluAnd: result = a & b;
			default: result = '0;
		endcase
	end

	// beq when equal, bne flips the sense
	assign cond = (diff == '0) ^ branchNe;

endmodule

`default_nettype wire

//--- source/exePkg.sv
`default_nettype none

package exePkg;

	localparam int xlen = 32;
	localparam int regAddrW = 5;

	// integer ALU functions
	typedef enum logic [3:0]
	{
		aluAdd,
		aluSub,
		aluSll,
		aluSlt,
		aluSltu,
		aluXor,
		aluSrl,
		aluSra,
		aluOr,
		aluAnd
	} aluOp_t;

	// RV32M multiply variants
	typedef enum logic [1:0]
	{
		mulLo,
		mulHigh,
		mulHighSu,
		mulHighU
	} mulOp_t;

	// writeback source, picked from pipe 6
	typedef enum logic [2:0]
	{
		wbAlu,
		wbLink,
		wbMul,
		wbLui,
		wbAuipc
	} wbSel_t;

	typedef enum logic [1:0]
	{
		modeUser = 2'd0,
		modeSupervisor = 2'd1,
		modeMachine = 2'd3
	} privMode_t;

	// exception codes, bit 31 of cause is added by the trap unit
	localparam logic [30:0] instrMisaligned = 31'd0;
	localparam logic [30:0] illegalInstr = 31'd2;
	localparam logic [30:0] userEcall = 31'd8; // plus current mode
	localparam logic [30:0] sTimerInt = 31'd5;
	localparam logic [30:0] mTimerInt = 31'd7;
	localparam logic [30:0] sExtInt = 31'd9;
	localparam logic [30:0] mExtInt = 31'd11;

endpackage

`default_nettype wire
